// ==== compile.f ====
src/hub75_pkg.sv
src/hub75_framebuf.sv
src/hub75_shifter.sv
src/hub75_bcm_timer.sv
src/hub75_scan.sv
src/hub75_phy.sv
src/hub75_top.sv
verification/hub75_sva.sv
verification/hub75_tb.sv

// ==== run_verilator.sh ====
#!/usr/bin/env bash
# Build the HUB75 testbench with Verilator and run it, exit status is the result
cd "$(dirname "$0")" && \
verilator --binary --assert -f compile.f --top-module hub75_tb -o hub75_sim && \
./obj_dir/hub75_sim || exit 1

// ==== src/hub75_bcm_timer.sv ====
// HUB75 bit plane on-time counter
// Binary coded modulation, plane p stays lit BASE_TIME << p cycles

module hub75_bcm_timer #(
	parameter int BASE_TIME = 4,
	localparam int MAX_TIME = BASE_TIME << (hub75_pkg::PIXEL_BITS - 1),
	localparam int CNT_W = $clog2(MAX_TIME + 1)
) (
	input  logic clk,
	input  logic rst,
	input  logic show_start,
	input  logic [hub75_pkg::PLANE_BITS-1:0] show_plane,
	output logic show_done
);

	logic active;
	logic [CNT_W-1:0] cnt;
	logic [CNT_W-1:0] on_time;

	// Weight of the plane being displayed
	assign on_time = CNT_W'(BASE_TIME) << show_plane;

	// Fires on_time cycles after the start pulse
	assign show_done = active && (cnt == '0);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			active <= 1'b0;
			cnt <= '0;
		end else if (show_start) begin
			active <= 1'b1;
			cnt <= on_time - 1'b1;
		end else if (active) begin
			if (show_done) begin
				active <= 1'b0;
			end else begin
				cnt <= cnt - 1'b1;
			end
		end
	end

endmodule

// ==== src/hub75_framebuf.sv ====
// HUB75 frame buffer
// Pixel storage for both panel banks, written by the host and
// read back one column at a time for the shifter

module hub75_framebuf #(
	parameter int N_ROWS = 8,
	parameter int N_COLS = 16,
	localparam int ROW_W = $clog2(N_ROWS),
	localparam int COL_W = $clog2(N_COLS),
	localparam int BANK_W = $clog2(hub75_pkg::N_BANKS)
) (
	input  logic clk,
	input  logic rst,

	// Host write port
	input  logic wr_en,
	input  logic [BANK_W-1:0] wr_bank,
	input  logic [ROW_W-1:0] wr_row,
	input  logic [COL_W-1:0] wr_col,
	input  hub75_pkg::pixel_t wr_pixel,

	// Shifter read port, bank 0 is the upper half
	input  logic [ROW_W-1:0] rd_row,
	input  logic [COL_W-1:0] rd_col,
	output hub75_pkg::pixel_t [hub75_pkg::N_BANKS-1:0] rd_pixels
);

	// Bank major storage, each bank holds rows x cols pixels
	hub75_pkg::pixel_t mem [hub75_pkg::N_BANKS][N_ROWS][N_COLS];

	// Host writes land on the next edge
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_bank][wr_row][wr_col] <= wr_pixel;
		end
	end

	// Both banks read from the same address so both halves shift together
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rd_pixels <= '0;
		end else begin
			for (int b = 0; b < hub75_pkg::N_BANKS; b++) begin
				rd_pixels[b] <= mem[b][rd_row][rd_col];
			end
		end
	end

endmodule

// ==== src/hub75_phy.sv ====
// HUB75 output stage
// Registers every panel signal, the panel clock gets one extra
// stage so its rising edge lands in the middle of the data

module hub75_phy #(
	parameter int N_ROWS = 8,
	localparam int ROW_W = $clog2(N_ROWS)
) (
	input  logic clk,
	input  logic rst,
	input  logic [ROW_W-1:0] phy_addr,
	input  hub75_pkg::bank_data_t phy_data,
	input  logic phy_clk,
	input  logic phy_le,
	input  logic phy_blank,
	output logic [ROW_W-1:0] hub75_addr,
	output hub75_pkg::bank_data_t hub75_data,
	output logic hub75_clk,
	output logic hub75_le,
	output logic hub75_blank
);

	// Flat pad bus for the colour lines
	logic [hub75_pkg::N_BANKS*hub75_pkg::N_CHANS-1:0] data_q;
	// Panel clock pipeline stage
	logic clk_d;

	assign hub75_data = data_q;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			hub75_addr <= '0;
			data_q <= '0;
			clk_d <= 1'b0;
			hub75_clk <= 1'b0;
			hub75_le <= 1'b0;
			// Panel stays dark out of reset
			hub75_blank <= 1'b1;
		end else begin
			hub75_addr <= phy_addr;
			data_q <= phy_data;
			clk_d <= phy_clk;
			hub75_clk <= clk_d;
			hub75_le <= phy_le;
			hub75_blank <= phy_blank;
		end
	end

endmodule

// ==== src/hub75_pkg.sv ====
// HUB75 panel driver shared definitions
// Panel geometry, pixel and data line structs, scan FSM states

package hub75_pkg;

	// Panel halves scanned at the same time
	localparam int N_BANKS = 2;

	// Colour channels per bank
	localparam int N_CHANS = 3;

	// Bits per channel, each one is a bit plane
	localparam int PIXEL_BITS = 4;
	localparam int PLANE_BITS = 2;

	// One frame buffer word
	typedef struct packed {
		logic [PIXEL_BITS-1:0] r;
		logic [PIXEL_BITS-1:0] g;
		logic [PIXEL_BITS-1:0] b;
	} pixel_t;

	// One bit plane slice of a pixel, for a single bank
	typedef struct packed {
		logic r;
		logic g;
		logic b;
	} rgb_bits_t;

	// The six colour lines on the connector
	typedef struct packed {
		rgb_bits_t lower;
		rgb_bits_t upper;
	} bank_data_t;

	// Row and plane sequencer states
	typedef enum logic [2:0] {
		st_idle,
		st_shift,
		st_wait_show,
		st_blank_latch,
		st_show
	} scan_state_t;

endpackage

// ==== src/hub75_scan.sv ====
// HUB75 row and plane sequencer
// Shifts the next bit plane while the current one is lit, then
// blanks, moves the row address, latches and unblanks the panel

module hub75_scan #(
	parameter int N_ROWS = 8,
	localparam int ROW_W = $clog2(N_ROWS)
) (
	input  logic clk,
	input  logic rst,
	input  logic shift_done,
	input  logic show_done,

	// To the shifter
	output logic shift_start,
	output logic [ROW_W-1:0] row,
	output logic [hub75_pkg::PLANE_BITS-1:0] plane,

	// To the on-time counter
	output logic show_start,
	output logic [hub75_pkg::PLANE_BITS-1:0] show_plane,

	// Panel control
	output logic [ROW_W-1:0] phy_addr,
	output logic phy_le,
	output logic phy_blank
);

	localparam logic [ROW_W-1:0] LAST_ROW = ROW_W'(N_ROWS - 1);
	localparam logic [hub75_pkg::PLANE_BITS-1:0] LAST_PLANE =
		hub75_pkg::PLANE_BITS'(hub75_pkg::PIXEL_BITS - 1);

	hub75_pkg::scan_state_t state;
	logic latch_ph;
	// Panel is showing a plane
	logic lit;

	// The next shift starts together with the show
	assign shift_start = (state == hub75_pkg::st_idle) || (state == hub75_pkg::st_show);
	assign show_start = (state == hub75_pkg::st_show);
	// Second cycle of blank_latch
	assign phy_le = (state == hub75_pkg::st_blank_latch) && latch_ph;
	// Dark once the on-time runs out, exactly in the done cycle
	assign phy_blank = !lit || show_done;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= hub75_pkg::st_idle;
			latch_ph <= 1'b0;
			row <= '0;
			plane <= '0;
			show_plane <= '0;
			phy_addr <= '0;
		end else begin
			case (state)
				hub75_pkg::st_idle: begin
					state <= hub75_pkg::st_shift;
				end
				hub75_pkg::st_shift: begin
					if (shift_done) begin
						state <= hub75_pkg::st_wait_show;
					end
				end
				hub75_pkg::st_wait_show: begin
					// Blank panel means the previous plane is over
					if (phy_blank) begin
						state <= hub75_pkg::st_blank_latch;
						latch_ph <= 1'b0;
						phy_addr <= row;
						show_plane <= plane;
						// Step to the next plane, rows wrap after the last plane
						if (plane == LAST_PLANE) begin
							plane <= '0;
							row <= (row == LAST_ROW) ? '0 : row + 1'b1;
						end else begin
							plane <= plane + 1'b1;
						end
					end
				end
				hub75_pkg::st_blank_latch: begin
					latch_ph <= 1'b1;
					if (latch_ph) begin
						state <= hub75_pkg::st_show;
						latch_ph <= 1'b0;
					end
				end
				hub75_pkg::st_show: begin
					state <= hub75_pkg::st_shift;
				end
				default: begin
					state <= hub75_pkg::st_idle;
				end
			endcase
		end
	end

	// Lit from the latch until the counter expires
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			lit <= 1'b0;
		end else if (phy_le) begin
			lit <= 1'b1;
		end else if (show_done) begin
			lit <= 1'b0;
		end
	end

endmodule

// ==== src/hub75_shifter.sv ====
// HUB75 column shifter
// Walks the columns of one row, slices the selected bit plane of
// both banks and drives panel data with its shift clock

module hub75_shifter #(
	parameter int N_ROWS = 8,
	parameter int N_COLS = 16,
	localparam int ROW_W = $clog2(N_ROWS),
	localparam int COL_W = $clog2(N_COLS),
	localparam int STEP_W = $clog2(2 * N_COLS + 2)
) (
	input  logic clk,
	input  logic rst,
	input  logic shift_start,
	input  logic [ROW_W-1:0] row,
	input  logic [hub75_pkg::PLANE_BITS-1:0] plane,
	input  hub75_pkg::pixel_t [hub75_pkg::N_BANKS-1:0] rd_pixels,
	output logic [ROW_W-1:0] rd_row,
	output logic [COL_W-1:0] rd_col,
	output hub75_pkg::bank_data_t phy_data,
	output logic phy_clk,
	output logic shift_done
);

	// Two steps per column plus one read priming step and the done step
	localparam logic [STEP_W-1:0] CLK_END = STEP_W'(2 * N_COLS);
	localparam logic [STEP_W-1:0] LAST_STEP = STEP_W'(2 * N_COLS + 1);

	logic busy;
	logic [STEP_W-1:0] step;
	logic [STEP_W-1:0] step_nxt;
	logic [hub75_pkg::PLANE_BITS-1:0] plane_q;
	logic load_col;

	assign step_nxt = step + 1'b1;
	// Read address stays one column ahead of the data register
	assign rd_col = step_nxt[COL_W:1];
	// Odd steps have fresh pixels on rd_pixels
	assign load_col = busy && step[0] && (step < CLK_END);
	assign shift_done = busy && (step == LAST_STEP);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			busy <= 1'b0;
			step <= '0;
			rd_row <= '0;
			plane_q <= '0;
		end else if (shift_start) begin
			busy <= 1'b1;
			step <= '0;
			rd_row <= row;
			plane_q <= plane;
		end else if (busy) begin
			step <= step_nxt;
			if (shift_done) begin
				busy <= 1'b0;
			end
		end
	end

	// New column and clock high together, PHY delays the clock one more cycle
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			phy_data <= '0;
			phy_clk <= 1'b0;
		end else begin
			phy_clk <= load_col;
			if (load_col) begin
				phy_data.upper.r <= rd_pixels[0].r[plane_q];
				phy_data.upper.g <= rd_pixels[0].g[plane_q];
				phy_data.upper.b <= rd_pixels[0].b[plane_q];
				phy_data.lower.r <= rd_pixels[1].r[plane_q];
				phy_data.lower.g <= rd_pixels[1].g[plane_q];
				phy_data.lower.b <= rd_pixels[1].b[plane_q];
			end
		end
	end

endmodule

// ==== src/hub75_top.sv ====
// HUB75 LED matrix driver
// Host writes pixels into the frame buffer, the panel is then
// refreshed row by row with binary coded modulation

module hub75_top #(
	parameter int N_ROWS = 8,
	parameter int N_COLS = 16,
	parameter int BASE_TIME = 4,
	localparam int ROW_W = $clog2(N_ROWS),
	localparam int COL_W = $clog2(N_COLS),
	localparam int BANK_W = $clog2(hub75_pkg::N_BANKS)
) (
	input  logic clk,
	input  logic rst,

	// Host pixel writes
	input  logic wr_en,
	input  logic [BANK_W-1:0] wr_bank,
	input  logic [ROW_W-1:0] wr_row,
	input  logic [COL_W-1:0] wr_col,
	input  hub75_pkg::pixel_t wr_pixel,

	// Panel connector
	output logic [ROW_W-1:0] hub75_addr,
	output hub75_pkg::bank_data_t hub75_data,
	output logic hub75_clk,
	output logic hub75_le,
	output logic hub75_blank
);

	// Frame buffer read path
	logic [ROW_W-1:0] rd_row;
	logic [COL_W-1:0] rd_col;
	hub75_pkg::pixel_t [hub75_pkg::N_BANKS-1:0] rd_pixels;

	// Sequencer handshake pulses
	logic shift_start;
	logic shift_done;
	logic [ROW_W-1:0] row;
	logic [hub75_pkg::PLANE_BITS-1:0] plane;
	logic show_start;
	logic show_done;
	logic [hub75_pkg::PLANE_BITS-1:0] show_plane;

	// Unregistered panel signals
	logic [ROW_W-1:0] phy_addr;
	hub75_pkg::bank_data_t phy_data;
	logic phy_clk;
	logic phy_le;
	logic phy_blank;

	hub75_framebuf #(
		.N_ROWS(N_ROWS),
		.N_COLS(N_COLS)
	) framebuf_inst (
		.clk(clk),
		.rst(rst),
		.wr_en(wr_en),
		.wr_bank(wr_bank),
		.wr_row(wr_row),
		.wr_col(wr_col),
		.wr_pixel(wr_pixel),
		.rd_row(rd_row),
		.rd_col(rd_col),
		.rd_pixels(rd_pixels)
	);

	hub75_shifter #(
		.N_ROWS(N_ROWS),
		.N_COLS(N_COLS)
	) shifter_inst (
		.clk(clk),
		.rst(rst),
		.shift_start(shift_start),
		.row(row),
		.plane(plane),
		.rd_pixels(rd_pixels),
		.rd_row(rd_row),
		.rd_col(rd_col),
		.phy_data(phy_data),
		.phy_clk(phy_clk),
		.shift_done(shift_done)
	);

	hub75_bcm_timer #(
		.BASE_TIME(BASE_TIME)
	) bcm_timer_inst (
		.clk(clk),
		.rst(rst),
		.show_start(show_start),
		.show_plane(show_plane),
		.show_done(show_done)
	);

	hub75_scan #(
		.N_ROWS(N_ROWS)
	) scan_inst (
		.clk(clk),
		.rst(rst),
		.shift_done(shift_done),
		.show_done(show_done),
		.shift_start(shift_start),
		.row(row),
		.plane(plane),
		.show_start(show_start),
		.show_plane(show_plane),
		.phy_addr(phy_addr),
		.phy_le(phy_le),
		.phy_blank(phy_blank)
	);

	hub75_phy #(
		.N_ROWS(N_ROWS)
	) phy_inst (
		.clk(clk),
		.rst(rst),
		.phy_addr(phy_addr),
		.phy_data(phy_data),
		.phy_clk(phy_clk),
		.phy_le(phy_le),
		.phy_blank(phy_blank),
		.hub75_addr(hub75_addr),
		.hub75_data(hub75_data),
		.hub75_clk(hub75_clk),
		.hub75_le(hub75_le),
		.hub75_blank(hub75_blank)
	);

endmodule

// ==== verification/hub75_sva.sv ====
// HUB75 panel protocol assertions
// Bound into the driver top, watches the registered panel outputs

module hub75_sva #(
	parameter int N_ROWS = 8,
	localparam int ROW_W = $clog2(N_ROWS)
) (
	input logic clk,
	input logic rst,
	input logic [ROW_W-1:0] hub75_addr,
	input logic hub75_clk,
	input logic hub75_le,
	input logic hub75_blank
);
	timeunit 1ns;
	timeprecision 1ps;

	// Latch only with the LEDs dark
	le_while_blank: assert property (@(posedge clk) disable iff (rst)
		hub75_le |-> hub75_blank)
		else $error("latch enable high while the panel is lit");

	// Row lines move only in the dark
	addr_while_blank: assert property (@(posedge clk) disable iff (rst)
		!$stable(hub75_addr) |-> hub75_blank)
		else $error("row address changed while the panel is lit");

	// No shift edge during the latch
	clk_low_at_le: assert property (@(posedge clk) disable iff (rst)
		hub75_le |-> !hub75_clk)
		else $error("panel clock high during latch enable");

endmodule

bind hub75_top hub75_sva #(
	.N_ROWS(N_ROWS)
) hub75_sva_inst (
	.clk(clk),
	.rst(rst),
	.hub75_addr(hub75_addr),
	.hub75_clk(hub75_clk),
	.hub75_le(hub75_le),
	.hub75_blank(hub75_blank)
);

// ==== verification/hub75_tb.sv ====
// HUB75 driver testbench
// Fills the frame buffer, writes table pixels during display and
// checks the panel stream against a shadow frame with a panel model

module hub75_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int N_ROWS = 8;
	localparam int N_COLS = 16;
	localparam int BASE_TIME = 4;
	localparam int ROW_W = $clog2(N_ROWS);
	localparam int COL_W = $clog2(N_COLS);
	localparam int BANK_W = $clog2(hub75_pkg::N_BANKS);
	localparam int PIX_W = $bits(hub75_pkg::pixel_t);
	localparam int N_PLANES = hub75_pkg::PIXEL_BITS;
	localparam int CLK_PERIOD = 4;
	localparam int RST_CYCLES = 16;
	localparam int N_FILL = hub75_pkg::N_BANKS * N_ROWS * N_COLS;
	localparam int N_TABLE = 8;
	// Upper bound of one frame, shift and on-time counted in series
	localparam int FRAME_CYCLES =
		N_ROWS * (N_PLANES * (2 * N_COLS + 6) + BASE_TIME * ((1 << N_PLANES) - 1));
	localparam int PLANE_CYCLES = 2 * N_COLS + 6 + (BASE_TIME << (N_PLANES - 1));
	localparam int WATCHDOG_CYCLES =
		RST_CYCLES + N_FILL + N_TABLE * PLANE_CYCLES + 2 * FRAME_CYCLES + 200;

	// One host write: bank, row, col, pixel
	typedef struct packed {
		logic [BANK_W-1:0] bank;
		logic [ROW_W-1:0] row;
		logic [COL_W-1:0] col;
		hub75_pkg::pixel_t px;
	} wr_entry_t;

	logic clk = 1'b0;
	logic rst;
	logic wr_en;
	logic [BANK_W-1:0] wr_bank;
	logic [ROW_W-1:0] wr_row;
	logic [COL_W-1:0] wr_col;
	hub75_pkg::pixel_t wr_pixel;
	logic [ROW_W-1:0] hub75_addr;
	hub75_pkg::bank_data_t hub75_data;
	logic hub75_clk;
	logic hub75_le;
	logic hub75_blank;

	wr_entry_t wr_table [N_TABLE];
	int seed = 67;
	int errors = 0;

	// Expected panel content and per row staleness
	hub75_pkg::pixel_t shadow [hub75_pkg::N_BANKS][N_ROWS][N_COLS];
	bit [N_ROWS-1:0] dirty = '1;

	// Panel model state
	hub75_pkg::bank_data_t cols [N_COLS];
	int clk_edges = 0;
	int latches = 0;
	int clean_run = 0;
	int low_count = 0;
	logic pclk_q = 1'b0;
	logic le_q = 1'b0;
	logic [ROW_W-1:0] exp_row = '0;
	logic [hub75_pkg::PLANE_BITS-1:0] exp_plane = '0;
	logic [hub75_pkg::PLANE_BITS-1:0] lit_plane = '0;

	always #(CLK_PERIOD / 2) clk = ~clk;

	hub75_top #(
		.N_ROWS(N_ROWS),
		.N_COLS(N_COLS),
		.BASE_TIME(BASE_TIME)
	) hub75_top_inst (
		.clk(clk),
		.rst(rst),
		.wr_en(wr_en),
		.wr_bank(wr_bank),
		.wr_row(wr_row),
		.wr_col(wr_col),
		.wr_pixel(wr_pixel),
		.hub75_addr(hub75_addr),
		.hub75_data(hub75_data),
		.hub75_clk(hub75_clk),
		.hub75_le(hub75_le),
		.hub75_blank(hub75_blank)
	);

	task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			errors++;
			$display("error at %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
			$display("Something failed");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	// Bit p of each channel, bank 0 drives the upper lines
	function automatic hub75_pkg::bank_data_t plane_bits(hub75_pkg::pixel_t up,
			hub75_pkg::pixel_t lo, int p);
		hub75_pkg::bank_data_t d;
		d.upper.r = up.r[p];
		d.upper.g = up.g[p];
		d.upper.b = up.b[p];
		d.lower.r = lo.r[p];
		d.lower.g = lo.g[p];
		d.lower.b = lo.b[p];
		return d;
	endfunction

	task automatic check_quiet_outputs();
		compare(32'(hub75_blank), 32'(1), "blank out of reset");
		compare(32'(hub75_le), 32'(0), "latch out of reset");
		compare(32'(hub75_clk), 32'(0), "panel clock out of reset");
		compare(32'(hub75_data), 32'(0), "panel data out of reset");
		compare(32'(hub75_addr), 32'(0), "row address out of reset");
	endtask

	task automatic check_latch();
		hub75_pkg::bank_data_t expected;
		compare(32'(clk_edges), 32'(N_COLS), "panel clock edges per latch");
		compare(32'(hub75_addr), 32'(exp_row), "row address at latch");
		if (dirty[exp_row]) begin
			// Row written while it was being shifted, wait for the next pass
			clean_run = 0;
		end else begin
			for (int c = 0; c < N_COLS; c++) begin
				expected = plane_bits(shadow[0][exp_row][c], shadow[1][exp_row][c],
					int'(exp_plane));
				compare(32'(cols[c]), 32'(expected),
					$sformatf("row %0d plane %0d col %0d data", exp_row, exp_plane, c));
			end
			clean_run++;
		end
		lit_plane = exp_plane;
		clk_edges = 0;
		latches++;
		if (int'(exp_plane) == N_PLANES - 1) begin
			dirty[exp_row] = 1'b0;
			exp_plane = '0;
			exp_row = (exp_row == ROW_W'(N_ROWS - 1)) ? '0 : exp_row + 1'b1;
		end else begin
			exp_plane = exp_plane + 1'b1;
		end
	endtask

	// Panel model, sampled on the falling edge where everything is settled
	always @(negedge clk) begin
		if (!rst) begin
			// Rising panel clock shifts one column in
			if (hub75_clk && !pclk_q) begin
				if (clk_edges < N_COLS) begin
					cols[clk_edges] = hub75_data;
				end
				clk_edges++;
			end
			if (hub75_le && !le_q) begin
				check_latch();
			end
			// On-time of the plane just latched
			if (!hub75_blank) begin
				low_count++;
			end else if (low_count != 0) begin
				compare(32'(low_count), 32'(BASE_TIME << lit_plane), "on-time of plane");
				low_count = 0;
			end
			// Host writes after the latch so a same cycle write keeps its row stale
			if (wr_en) begin
				shadow[wr_bank][wr_row][wr_col] = wr_pixel;
				dirty[wr_row] = 1'b1;
				clean_run = 0;
			end
		end
		pclk_q = hub75_clk;
		le_q = hub75_le;
	end

	initial begin
		int target;
		logic [31:0] rnd;
		rst = 1'b1;
		wr_en = 1'b0;
		wr_bank = '0;
		wr_row = '0;
		wr_col = '0;
		wr_pixel = '0;
		wr_table[0] = {1'b0, 3'd0, 4'd0, 12'hfff};
		wr_table[1] = {1'b1, 3'd7, 4'd15, 12'ha5a};
		wr_table[2] = {1'b0, 3'd3, 4'd8, 12'h0f0};
		wr_table[3] = {1'b1, 3'd0, 4'd1, 12'h00f};
		wr_table[4] = {1'b0, 3'd7, 4'd0, 12'h123};
		wr_table[5] = {1'b1, 3'd4, 4'd9, 12'hc3c};
		wr_table[6] = {1'b0, 3'd5, 4'd15, 12'h800};
		wr_table[7] = {1'b1, 3'd2, 4'd7, 12'h7e1};
		repeat (RST_CYCLES - 1) @(posedge clk);
		@(negedge clk);
		check_quiet_outputs();
		@(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_quiet_outputs();

		// Random fill of the whole buffer while the scan already runs
		for (int b = 0; b < hub75_pkg::N_BANKS; b++) begin
			for (int r = 0; r < N_ROWS; r++) begin
				for (int c = 0; c < N_COLS; c++) begin
					@(posedge clk);
					rnd = $random(seed);
					wr_en <= 1'b1;
					wr_bank <= BANK_W'(b);
					wr_row <= ROW_W'(r);
					wr_col <= COL_W'(c);
					wr_pixel <= rnd[PIX_W-1:0];
				end
			end
		end
		@(posedge clk);
		wr_en <= 1'b0;

		// Table writes, one after each latch while a plane is lit
		for (int i = 0; i < N_TABLE; i++) begin
			target = latches + 1;
			while (latches < target) begin
				@(posedge clk);
			end
			wr_en <= 1'b1;
			wr_bank <= wr_table[i].bank;
			wr_row <= wr_table[i].row;
			wr_col <= wr_table[i].col;
			wr_pixel <= wr_table[i].px;
			@(posedge clk);
			wr_en <= 1'b0;
		end

		// One whole frame compared after the last write
		while (clean_run < N_ROWS * N_PLANES) begin
			@(posedge clk);
		end
		if (errors == 0) begin
			$display("Everything OK");
			$finish;
		end else begin
			$display("Something failed");
			$fatal(1, "checks reported mismatches");
		end
	end

	// Watchdog
	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout: the panel did not show a full clean frame in time");
		$display("Something failed");
		$fatal(1, "watchdog expired");
	end

endmodule
